// File: common/img_proc_pkg.sv
`default_nettype none

package img_proc_pkg;

	//////////////////////////////
	// Image geometry
	//////////////////////////////

	localparam int unsigned coord_w = 11;	// Enough for 640 and 480
	localparam int unsigned image_w = 640;
	localparam int unsigned image_h = 480;

	typedef logic [coord_w-1:0] coord_t;

	//////////////////////////////
	// Pixels and stream words
	//////////////////////////////

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	// Same bit order as {data, sop, eop} on the stream ports
	typedef struct packed {
		pixel_t data;
		logic sop;
		logic eop;
	} stream_beat_t;

	// Locator view of the beat currently in the input stage
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic bright;		// Top bit of all three channels set
		logic in_video;		// Video packet, not the descriptor word
		logic first;		// Packet descriptor word
		logic last;		// End of packet
	} pixel_info_t;

	typedef struct packed {
		coord_t left;
		coord_t right;
		coord_t top;
		coord_t bottom;
	} bbox_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam pixel_t bb_col_default = 24'h00ff00;	// Green

	localparam logic [2:0] addr_bb_col = 3'd0;	// Box colour, read/write
	localparam logic [2:0] addr_box_x = 3'd1;	// Left and right, read only
	localparam logic [2:0] addr_box_y = 3'd2;	// Top and bottom, read only

endpackage

`default_nettype wire

// File: rtl/stream_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stream_reg
	import img_proc_pkg::*;
(
	input logic clk,
	input logic reset_n,

	// Upstream side
	input logic in_valid,
	output logic in_ready,
	input stream_beat_t in_beat,

	// Downstream side
	output logic out_valid,
	input logic out_ready,
	output stream_beat_t out_beat
);

	logic load;

	// Free slot, or the held beat leaves this cycle
	assign in_ready = ~out_valid | out_ready;
	assign load = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid <= 1'b0;
		end
		else if (in_ready) begin
			out_valid <= in_valid;	// Drops to 0 once taken with nothing behind it
		end
	end

	// Payload only moves on a real transfer
	always_ff @(posedge clk) begin
		if (load) begin
			out_beat <= in_beat;
		end
	end

endmodule

`default_nettype wire

// File: rtl/csr_slave.sv
`timescale 1ns/1ps
`default_nettype none

module csr_slave
	import img_proc_pkg::*;
(
	input logic clk,
	input logic reset_n,

	// Memory-mapped port
	input logic chipselect,
	input logic read,
	input logic write,
	input logic [2:0] address,
	input logic [31:0] writedata,
	output logic [31:0] readdata,

	input bbox_t box,	// Latched box from the last video frame
	output pixel_t bb_col
);

	logic wr_en;
	logic rd_en;

	assign wr_en = chipselect & write;
	assign rd_en = chipselect & read;

	//////////////////////////////
	// Writes
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			bb_col <= bb_col_default;
		end
		else if (wr_en && address == addr_bb_col) begin
			bb_col <= writedata[23:0];
		end
	end

	//////////////////////////////
	// Reads, one cycle latency
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= '0;
		end
		else if (rd_en) begin
			case (address)
				addr_bb_col:
					readdata <= {8'h00, bb_col};
				addr_box_x:
					readdata <= {5'b0, box.right, 5'b0, box.left};
				addr_box_y:
					readdata <= {5'b0, box.bottom, 5'b0, box.top};
				default:
					readdata <= '0;	// Unmapped
			endcase
		end
	end

endmodule

`default_nettype wire

// File: video_path/pixel_locator.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_locator
	import img_proc_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input stream_beat_t beat,
	input logic advance,	// Beat moves on this cycle
	output pixel_info_t info
);

	coord_t x;
	coord_t y;
	logic packet_video;	// Type of the packet in progress

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			packet_video <= 1'b0;
		end
		else if (advance) begin
			if (beat.sop) begin
				x <= '0;
				y <= '0;
				packet_video <= (beat.data.blue[3:0] == 4'h0);	// Video descriptor
			end
			else if (x == coord_t'(image_w - 1)) begin
				x <= '0;	// End of line
				y <= y + 1'b1;
			end
			else begin
				x <= x + 1'b1;
			end
		end
	end

	assign info.x = x;
	assign info.y = y;
	assign info.bright = beat.data.red[7] & beat.data.green[7] & beat.data.blue[7];
	assign info.in_video = packet_video & ~beat.sop;
	assign info.first = beat.sop;
	assign info.last = beat.eop;

endmodule

`default_nettype wire

// File: video_path/bbox_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module bbox_accumulator
	import img_proc_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input pixel_info_t info,
	input logic advance,
	output bbox_t box	// Box of the last complete video frame
);

	// Minima at the far corner, maxima at zero
	localparam bbox_t empty_box = '{
		left: coord_t'(image_w - 1),
		right: '0,
		top: coord_t'(image_h - 1),
		bottom: '0
	};

	bbox_t run;		// Running bounds of the frame in progress
	bbox_t run_nxt;		// Running bounds including the current beat
	logic hit;

	assign hit = info.bright & info.in_video;

	always_comb begin
		run_nxt = run;
		if (hit) begin
			if (info.x < run.left)
				run_nxt.left = info.x;
			if (info.x > run.right)
				run_nxt.right = info.x;
			if (info.y < run.top)
				run_nxt.top = info.y;
			if (info.y > run.bottom)
				run_nxt.bottom = info.y;
		end
	end

	//////////////////////////////
	// Running bounds and latch
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			run <= empty_box;
			box <= empty_box;
		end
		else if (advance) begin
			if (info.first) begin
				run <= empty_box;	// New packet starts clean
			end
			else begin
				run <= run_nxt;
			end

			// Non-video packets leave the latched box alone
			if (info.last && info.in_video) begin
				box <= run_nxt;
			end
		end
	end

endmodule

`default_nettype wire

// File: video_path/overlay_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_mixer
	import img_proc_pkg::*;
(
	input stream_beat_t beat,
	input pixel_info_t info,
	input bbox_t box,
	input pixel_t bb_col,
	input logic mode,
	output stream_beat_t out_beat
);

	localparam pixel_t white = 24'hffffff;

	pixel_t px;
	logic [7:0] grey;
	logic edge_hit;

	assign px = beat.data;

	// green/2 + red/4 + blue/4, peaks at 253 so no overflow
	assign grey = {1'b0, px.green[7:1]} + {2'b00, px.red[7:2]} + {2'b00, px.blue[7:2]};

	assign edge_hit = (info.x == box.left) | (info.x == box.right) |
		(info.y == box.top) | (info.y == box.bottom);

	always_comb begin
		out_beat = beat;	// sop and eop always pass through
		if (mode && info.in_video) begin
			if (edge_hit) begin
				out_beat.data = bb_col;
			end
			else if (info.bright) begin
				out_beat.data = white;
			end
			else begin
				out_beat.data = {grey, grey, grey};
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/img_proc_top.sv
`timescale 1ns/1ps
`default_nettype none

module img_proc_top
	import img_proc_pkg::*;
(
	input logic clk,
	input logic reset_n,

	// Register port
	input logic s_chipselect,
	input logic s_read,
	input logic s_write,
	input logic [2:0] s_address,
	input logic [31:0] s_writedata,
	output logic [31:0] s_readdata,

	// Video in
	input logic [23:0] sink_data,
	input logic sink_valid,
	output logic sink_ready,
	input logic sink_sop,
	input logic sink_eop,

	// Video out
	output logic [23:0] source_data,
	output logic source_valid,
	input logic source_ready,
	output logic source_sop,
	output logic source_eop,

	input logic mode	// High selects the overlay view
);

	stream_beat_t sink_beat;
	stream_beat_t cur_beat;		// Beat held in the input stage
	stream_beat_t mixed_beat;
	stream_beat_t source_beat;
	logic in_valid;
	logic out_ready;
	logic advance;
	pixel_info_t info;
	bbox_t box;
	pixel_t bb_col;

	assign sink_beat.data = sink_data;
	assign sink_beat.sop = sink_sop;
	assign sink_beat.eop = sink_eop;

	assign source_data = source_beat.data;
	assign source_sop = source_beat.sop;
	assign source_eop = source_beat.eop;

	// Input stage beat moves into the output stage
	assign advance = in_valid & out_ready;

	//////////////////////////////
	// Stream stages
	//////////////////////////////

	stream_reg in_stage (
		.clk(clk),
		.reset_n(reset_n),
		.in_valid(sink_valid),
		.in_ready(sink_ready),
		.in_beat(sink_beat),
		.out_valid(in_valid),
		.out_ready(out_ready),
		.out_beat(cur_beat)
	);

	stream_reg out_stage (
		.clk(clk),
		.reset_n(reset_n),
		.in_valid(in_valid),
		.in_ready(out_ready),
		.in_beat(mixed_beat),
		.out_valid(source_valid),
		.out_ready(source_ready),
		.out_beat(source_beat)
	);

	//////////////////////////////
	// Video path
	//////////////////////////////

	pixel_locator u_locator (
		.clk(clk),
		.reset_n(reset_n),
		.beat(cur_beat),
		.advance(advance),
		.info(info)
	);

	bbox_accumulator u_bbox (
		.clk(clk),
		.reset_n(reset_n),
		.info(info),
		.advance(advance),
		.box(box)
	);

	overlay_mixer u_mixer (
		.beat(cur_beat),
		.info(info),
		.box(box),
		.bb_col(bb_col),
		.mode(mode),
		.out_beat(mixed_beat)
	);

	csr_slave u_csr (
		.clk(clk),
		.reset_n(reset_n),
		.chipselect(s_chipselect),
		.read(s_read),
		.write(s_write),
		.address(s_address),
		.writedata(s_writedata),
		.readdata(s_readdata),
		.box(box),
		.bb_col(bb_col)
	);

endmodule

`default_nettype wire

// File: verif/img_proc_properties.sv
`timescale 1ns/1ps
`default_nettype none

module img_proc_properties (
	input logic clk,
	input logic reset_n,
	input logic [23:0] source_data,
	input logic source_valid,
	input logic source_ready,
	input logic source_sop,
	input logic source_eop
);

	// Output stage is empty right after a reset cycle
	assert property (@(posedge clk) !reset_n |=> !source_valid)
		else $error("source_valid high after reset");

	assert property (@(posedge clk) disable iff (!reset_n)
		!$isunknown(source_valid))
		else $error("source_valid unknown");

	// Stalled beat must stay put
	assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && !source_ready |=>
		source_valid && $stable(source_data) && $stable(source_sop) && $stable(source_eop))
		else $error("source beat changed while stalled");

endmodule

`default_nettype wire

// File: verif/img_proc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module img_proc_tb
	import img_proc_pkg::*;
;

	localparam int num_pkts = 10;
	localparam int pkt_lines = 4;	// Short packets keep the run fast
	localparam int pkt_pixels = image_w * pkt_lines;
	localparam int cycle_limit = num_pkts * (pkt_pixels + 1) * 3 + 1000;
	localparam int colour_pkt = 5;	// New box colour written before this packet

	logic clk, reset_n, mode;
	logic s_chipselect, s_read, s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata, s_readdata;
	logic [23:0] sink_data, source_data;
	logic sink_valid, sink_ready, sink_sop, sink_eop;
	logic source_valid, source_ready, source_sop, source_eop;

	logic [15:0] vec [0:num_pkts*12-1];
	logic [25:0] exp_q[$];	// Predicted source beats, oldest first
	logic [31:0] rng;
	logic bp_on;
	int cycles = 0;
	int out_count = 0;
	int box_l = image_w - 1;	// Reference copy of the latched box
	int box_r = 0;
	int box_t = image_h - 1;
	int box_b = 0;
	pixel_t model_col = bb_col_default;

	img_proc_top dut (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.sink_data(sink_data), .sink_valid(sink_valid), .sink_ready(sink_ready),
		.sink_sop(sink_sop), .sink_eop(sink_eop),
		.source_data(source_data), .source_valid(source_valid),
		.source_ready(source_ready), .source_sop(source_sop), .source_eop(source_eop),
		.mode(mode)
	);

	bind img_proc_top img_proc_properties props (
		.clk(clk), .reset_n(reset_n), .source_data(source_data),
		.source_valid(source_valid), .source_ready(source_ready),
		.source_sop(source_sop), .source_eop(source_eop)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v ^= v << 13;
		v ^= v >> 17;
		v ^= v << 5;
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	//////////////////////////////
	// Cycle stepping and bus access
	//////////////////////////////

	task automatic next_cycle();
		@(negedge clk);
		if (bp_on) begin
			rng = xorshift(rng);
			source_ready = (rng[3:2] != 2'b00);	// Stall about one cycle in four
		end
		else begin
			source_ready = 1'b1;
		end
	endtask

	task automatic send_word(input pixel_t d, input logic sop, input logic eop);
		logic taken;
		if (bp_on) begin
			rng = xorshift(rng);
			while (rng[1:0] == 2'b00) begin
				sink_valid = 1'b0;	// Gap on the sink
				next_cycle();
				rng = xorshift(rng);
			end
		end
		sink_valid = 1'b1;
		sink_data = d;
		sink_sop = sop;
		sink_eop = eop;
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = sink_ready;
			next_cycle();
		end
		sink_valid = 1'b0;
	endtask

	task automatic csr_write(input logic [2:0] addr, input logic [31:0] data);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		next_cycle();
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	task automatic csr_read(input logic [2:0] addr, output logic [31:0] data);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		next_cycle();
		data = s_readdata;	// Registered one cycle after the request
		s_chipselect = 1'b0;
		s_read = 1'b0;
	endtask

	// Overlay rules applied to one pixel of a video packet
	function automatic pixel_t expect_pixel(input pixel_t p, input int x, input int y,
		input logic overlay, input logic bright);
		logic [7:0] g;
		g = p.green / 2 + p.red / 4 + p.blue / 4;
		if (!overlay)
			return p;
		if (x == box_l || x == box_r || y == box_t || y == box_b)
			return model_col;
		if (bright)
			return 24'hffffff;
		return {g, g, g};
	endfunction

	task automatic send_packet(input int idx);
		int base, x, y, run_l, run_r, run_t, run_b;
		logic vid, in_rect, bright, last;
		logic [31:0] rd;
		pixel_t p;
		base = idx * 12;
		vid = vec[base+1][0];
		mode = vec[base][0];
		bp_on = vec[base+7][0];
		run_l = image_w - 1;
		run_r = 0;
		run_t = image_h - 1;
		run_b = 0;
		p = vid ? 24'h000000 : 24'h000001;	// Descriptor word
		exp_q.push_back({p, 1'b1, 1'b0});
		send_word(p, 1'b1, 1'b0);
		for (int i = 0; i < pkt_pixels; i++) begin
			x = i % image_w;
			y = i / image_w;
			last = (i == pkt_pixels - 1);
			in_rect = vec[base+2][0] && x >= vec[base+3] && x <= vec[base+4] &&
				y >= vec[base+5] && y <= vec[base+6];
			if (in_rect) begin
				p = 24'hffffff;
			end
			else begin
				rng = xorshift(rng);
				p = rng[23:0];
				p.red[7] = 1'b0;	// Never bright
			end
			bright = p.red[7] & p.green[7] & p.blue[7];
			exp_q.push_back({expect_pixel(p, x, y, mode & vid, bright), 1'b0, last});
			if (vid && bright) begin
				run_l = (x < run_l) ? x : run_l;
				run_r = (x > run_r) ? x : run_r;
				run_t = (y < run_t) ? y : run_t;
				run_b = (y > run_b) ? y : run_b;
			end
			send_word(p, 1'b0, last);
		end
		while (exp_q.size() > 0)
			next_cycle();
		if (vid) begin
			box_l = run_l;
			box_r = run_r;
			box_t = run_t;
			box_b = run_b;
		end
		check($sformatf("pkt %0d model box x", idx), {vec[base+9], vec[base+8]},
			{box_r[15:0], box_l[15:0]});
		check($sformatf("pkt %0d model box y", idx), {vec[base+11], vec[base+10]},
			{box_b[15:0], box_t[15:0]});
		csr_read(addr_box_x, rd);
		check($sformatf("pkt %0d box x", idx), {vec[base+9], vec[base+8]}, rd);
		csr_read(addr_box_y, rd);
		check($sformatf("pkt %0d box y", idx), {vec[base+11], vec[base+10]}, rd);
	endtask

	//////////////////////////////
	// Monitor and timeout
	//////////////////////////////

	always @(posedge clk) begin
		if (reset_n && source_valid && source_ready) begin
			if (exp_q.size() == 0) begin
				$display("Source sent beat %0d when no beat was expected", out_count);
				$display("*** FAILED ***");
				$fatal(1, "Unexpected output beat");
			end
			else begin
				check($sformatf("source beat %0d", out_count), exp_q.pop_front(),
					{source_data, source_sop, source_eop});
				out_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Run did not finish within %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		logic [31:0] rd;
		reset_n = 1'b0;
		mode = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		source_ready = 1'b1;
		rng = 32'd37223;
		bp_on = 1'b0;
		$readmemh("verif/img_proc_vectors.txt", vec);
		repeat (4) @(posedge clk);
		next_cycle();
		reset_n = 1'b1;
		csr_read(addr_bb_col, rd);
		check("reset colour", {8'h00, bb_col_default}, rd);
		for (int i = 0; i < num_pkts; i++) begin
			if (i == colour_pkt) begin
				csr_write(addr_bb_col, 32'h55c03090);	// Upper byte is ignored
				model_col = 24'hc03090;
				csr_read(addr_bb_col, rd);
				check("written colour", 32'h00c03090, rd);
			end
			send_packet(i);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/img_proc_vectors.txt
// One packet per line, hex: mode video has_rect x0 x1 y0 y1 backpressure
// then the box expected on readback: left right top bottom
1 1 1 00a 014 001 003 0 00a 014 001 003
1 1 0 000 000 000 000 0 27f 000 1df 000
0 1 1 12c 136 000 003 0 12c 136 000 003
1 0 1 005 006 001 001 0 12c 136 000 003
0 0 0 000 000 000 000 1 12c 136 000 003
1 1 1 258 27f 002 003 0 258 27f 002 003
1 1 1 000 000 000 000 1 000 000 000 000
1 1 1 032 190 001 002 1 032 190 001 002
0 1 0 000 000 000 000 1 27f 000 1df 000
1 1 1 140 141 002 003 1 140 141 002 003

// File: filelist.f
common/img_proc_pkg.sv
rtl/stream_reg.sv
rtl/csr_slave.sv
video_path/pixel_locator.sv
video_path/bbox_accumulator.sv
video_path/overlay_mixer.sv
rtl/img_proc_top.sv
verif/img_proc_properties.sv
verif/img_proc_tb.sv
